// ==== common/streamPkg.sv ====
package streamPkg;

    // widths of the stream payload
    localparam int wordBits  = 32;
    localparam int countBits = 6;   // holds 0..32

    // one data word as the producer writes it
    typedef logic [wordBits-1:0] wordT;

    // number of set bits in a word
    typedef logic [countBits-1:0] countT;

    // count in the upper bits, word in the lower bits
    typedef logic [countBits+wordBits-1:0] resultT;

    // cycles from issue to the output FIFO write
    localparam int pipeStages = 3;

endpackage

// ==== fifo/syncFifo.sv ====
`timescale 1ns/1ns

module syncFifo #(
    parameter int width            = 32,
    parameter int depthLog2        = 4,
    parameter int almostFullMargin = 2
) (
    input  logic             rdclk,
    input  logic             wrrst,

    // write side
    input  logic             writeEnable,
    input  logic [width-1:0] dataIn,
    output logic             almostFull,

    // read side, show-ahead
    input  logic             readEnable,
    output logic [width-1:0] dataOut,
    output logic             empty
);

    localparam int depth = 1 << depthLog2;

    // one extra head bit so a completely full FIFO is not seen as empty
    localparam logic [depthLog2:0] almostFullLevel =
        (depthLog2 + 1)'(depth - almostFullMargin);

    logic [width-1:0] mem [depth];

    logic [depthLog2:0] writeHead;
    logic [depthLog2:0] readHead;
    logic [depthLog2:0] used;

    assign used = writeHead - readHead;    // wraps on purpose

    assign empty      = (used == '0);
    assign almostFull = (used >= almostFullLevel);

    // look-ahead data, valid whenever empty is low
    assign dataOut = mem[readHead[depthLog2-1:0]];

    always_ff @(posedge rdclk) begin
        if (wrrst) begin
            writeHead <= '0;
            readHead  <= '0;
        end else begin
            if (writeEnable) begin
                writeHead <= writeHead + 1'b1;
            end
            if (readEnable) begin
                readHead <= readHead + 1'b1;
            end
        end
    end

    // storage itself keeps no reset
    always_ff @(posedge rdclk) begin
        if (writeEnable) begin
            mem[writeHead[depthLog2-1:0]] <= dataIn;
        end
    end

endmodule

// ==== source/popcountPipe.sv ====
`timescale 1ns/1ns

module popcountPipe (
    input  logic             rdclk,
    input  logic             wrrst,

    // from the input FIFO, show-ahead
    input  logic             inEmpty,
    input  streamPkg::wordT  inData,
    output logic             inRead,

    // to the output FIFO
    input  logic             outAlmostFull,
    output logic             outWrite,
    output streamPkg::resultT outData
);

    import streamPkg::*;

    // set bits of one byte, 0..8
    function automatic logic [3:0] byteCount(input logic [7:0] b);
        logic [3:0] n;
        n = '0;
        for (int i = 0; i < 8; i++) begin
            n = n + 4'(b[i]);
        end
        return n;
    endfunction

    logic [pipeStages-1:0] validChain;  // bit k set when stage k+1 holds a word

    logic [3:0] byteCnt [4];            // combinational, from inData

    // stage one
    wordT       s1Word;
    logic [3:0] s1ByteCnt [4];

    // stage two
    wordT       s2Word;
    logic [4:0] s2HalfCnt [2];

    // stage three
    wordT       s3Word;
    countT      s3Count;

    // the output margin already covers everything in flight
    assign inRead = !inEmpty && !outAlmostFull;

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            byteCnt[k] = byteCount(inData[8*k +: 8]);
        end
    end

    always_ff @(posedge rdclk) begin
        if (wrrst) begin
            validChain <= '0;
        end else begin
            validChain <= {validChain[pipeStages-2:0], inRead};
        end
    end

    always_ff @(posedge rdclk) begin
        if (inRead) begin
            s1Word <= inData;
            for (int k = 0; k < 4; k++) begin
                s1ByteCnt[k] <= byteCnt[k];
            end
        end
    end

    always_ff @(posedge rdclk) begin
        if (validChain[0]) begin
            s2Word       <= s1Word;
            s2HalfCnt[0] <= 5'(s1ByteCnt[0]) + 5'(s1ByteCnt[1]);   // low half
            s2HalfCnt[1] <= 5'(s1ByteCnt[2]) + 5'(s1ByteCnt[3]);   // high half
        end
    end

    always_ff @(posedge rdclk) begin
        if (validChain[1]) begin
            s3Word  <= s2Word;
            s3Count <= countT'(s2HalfCnt[0]) + countT'(s2HalfCnt[1]);
        end
    end

    assign outWrite = validChain[pipeStages-1];
    assign outData  = {s3Count, s3Word};

endmodule

// ==== source/countStreamTop.sv ====
`timescale 1ns/1ns

module countStreamTop #(
    parameter int inDepthLog2  = 4,
    parameter int outDepthLog2 = 4
) (
    input  logic              rdclk,
    input  logic              wrrst,

    // producer side
    input  logic              writeEnable,
    input  streamPkg::wordT   dataIn,
    output logic              almostFull,

    // consumer side
    input  logic              readEnable,
    output streamPkg::resultT dataOut,
    output logic              empty
);

    import streamPkg::*;

    // input FIFO to pipeline
    logic   inEmpty;
    wordT   inData;
    logic   inRead;

    // pipeline to output FIFO
    logic   outWrite;
    resultT outData;
    logic   outAlmostFull;

    syncFifo #(
        .width            ($bits(wordT)),
        .depthLog2        (inDepthLog2),
        .almostFullMargin (2)
    ) u_inFifo (
        .rdclk       (rdclk),
        .wrrst       (wrrst),
        .writeEnable (writeEnable),
        .dataIn      (dataIn),
        .almostFull  (almostFull),
        .readEnable  (inRead),
        .dataOut     (inData),
        .empty       (inEmpty)
    );

    popcountPipe u_pipe (
        .rdclk         (rdclk),
        .wrrst         (wrrst),
        .inEmpty       (inEmpty),
        .inData        (inData),
        .inRead        (inRead),
        .outAlmostFull (outAlmostFull),
        .outWrite      (outWrite),
        .outData       (outData)
    );

    // margin leaves room for every word still in the pipeline
    syncFifo #(
        .width            ($bits(resultT)),
        .depthLog2        (outDepthLog2),
        .almostFullMargin (pipeStages + 1)
    ) u_outFifo (
        .rdclk       (rdclk),
        .wrrst       (wrrst),
        .writeEnable (outWrite),
        .dataIn      (outData),
        .almostFull  (outAlmostFull),
        .readEnable  (readEnable),
        .dataOut     (dataOut),
        .empty       (empty)
    );

endmodule

// ==== tests/countStream_assertions.sv ====
`timescale 1ns/1ns

module countStream_assertions #(
    parameter int inDepthLog2  = 4,
    parameter int outDepthLog2 = 4
) (
    input logic rdclk,
    input logic wrrst,
    input logic writeEnable,
    input logic inRead,
    input logic outWrite,
    input logic readEnable,
    input logic empty
);

    import streamPkg::*;

    localparam int inDepth  = 1 << inDepthLog2;
    localparam int outDepth = 1 << outDepthLog2;

    // occupancy rebuilt from the handshakes
    int inUsed;
    int outUsed;

    always_ff @(posedge rdclk) begin
        if (wrrst) begin
            inUsed  <= 0;
            outUsed <= 0;
        end else begin
            inUsed  <= inUsed + (writeEnable ? 1 : 0) - (inRead ? 1 : 0);
            outUsed <= outUsed + (outWrite ? 1 : 0) - (readEnable ? 1 : 0);
        end
    end

    inNoOverflow: assert property (@(posedge rdclk) disable iff (wrrst)
        !(writeEnable && inUsed >= inDepth))
        else $error("write into the input FIFO while it is full");

    outNoOverflow: assert property (@(posedge rdclk) disable iff (wrrst)
        !(outWrite && outUsed >= outDepth))
        else $error("write into the output FIFO while it is full");

    inNoUnderflow: assert property (@(posedge rdclk) disable iff (wrrst)
        !(inRead && inUsed == 0))
        else $error("read from the empty input FIFO");

    outNoUnderflow: assert property (@(posedge rdclk) disable iff (wrrst)
        !(readEnable && empty))
        else $error("read from the empty output FIFO");

    // in-flight words rely on the output margin
    issueHeld: assert property (@(posedge rdclk) disable iff (wrrst)
        !(inRead && outUsed >= outDepth - pipeStages - 1))
        else $error("pipeline issued while the output FIFO was almost full");

endmodule

bind countStreamTop countStream_assertions #(
    .inDepthLog2  (inDepthLog2),
    .outDepthLog2 (outDepthLog2)
) u_assertions (
    .rdclk         (rdclk),
    .wrrst         (wrrst),
    .writeEnable   (writeEnable),
    .inRead        (inRead),
    .outWrite      (outWrite),
    .readEnable    (readEnable),
    .empty         (empty)
);

// ==== tests/countStreamTb.sv ====
`timescale 1ns/1ns

module countStreamTb;

    import streamPkg::*;

    localparam int inDepthLog2  = 4;
    localparam int outDepthLog2 = 4;

    // about 300 words at up to pipeStages+2 cycles each, plus gaps, doubled
    localparam int timeoutCycles = 3000;

    logic   rdclk;
    logic   wrrst;
    logic   writeEnable;
    wordT   dataIn;
    logic   almostFull;
    logic   readEnable;
    resultT dataOut;
    logic   empty;

    wordT   expectedWords [$];    // scoreboard, oldest first
    int     cycleCount = 0;
    int     seedDummy;

    countStreamTop #(
        .inDepthLog2  (inDepthLog2),
        .outDepthLog2 (outDepthLog2)
    ) u_dut (
        .rdclk       (rdclk),
        .wrrst       (wrrst),
        .writeEnable (writeEnable),
        .dataIn      (dataIn),
        .almostFull  (almostFull),
        .readEnable  (readEnable),
        .dataOut     (dataOut),
        .empty       (empty)
    );

    always #10 rdclk = ~rdclk;

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    always @(posedge rdclk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            failRun($sformatf("timeout: the tests did not finish within %0d cycles",
                              timeoutCycles));
        end
    end

    // reference count, one bit at a time
    function automatic countT countSetBits(input wordT w);
        countT n;
        n = '0;
        for (int i = 0; i < $bits(wordT); i++) begin
            if (w[i]) begin
                n = n + countT'(1);
            end
        end
        return n;
    endfunction

    // compare the show-ahead output with the oldest word written
    task automatic checkResult();
        wordT   w;
        resultT expected;
        assert (expectedWords.size() > 0)
            else failRun("a result appeared with no word left in the scoreboard");
        w        = expectedWords.pop_front();
        expected = {countSetBits(w), w};
        assert (dataOut === expected)
            else failRun($sformatf("ERROR: dataOut expected 0x%h actual 0x%h",
                                   expected, dataOut));
    endtask

    // after the last read no further result may appear
    task automatic checkNoExtraResults();
        repeat (pipeStages + 2) @(negedge rdclk);
        assert (empty === 1'b1)
            else failRun($sformatf("ERROR: empty expected 0x1 actual 0x%h", empty));
    endtask

    task automatic sendWord(input wordT w);
        while (almostFull) begin
            @(negedge rdclk);
        end
        writeEnable = 1'b1;
        dataIn      = w;
        expectedWords.push_back(w);
        @(negedge rdclk);
        writeEnable = 1'b0;
    endtask

    task automatic readOne(output resultT got);
        while (empty) begin
            @(negedge rdclk);
        end
        got = dataOut;
        checkResult();
        readEnable = 1'b1;
        @(negedge rdclk);
        readEnable = 1'b0;
    endtask

    task automatic checkReset();
        wrrst = 1'b1;
        repeat (5) @(negedge rdclk);
        wrrst = 1'b0;
        assert (empty === 1'b1)
            else failRun($sformatf("ERROR: empty expected 0x1 actual 0x%h", empty));
        assert (almostFull === 1'b0)
            else failRun($sformatf("ERROR: almostFull expected 0x0 actual 0x%h", almostFull));
    endtask

    task automatic singleWord();
        int     waited;
        resultT got;
        waited = 0;
        sendWord(32'h1234_5678);
        while (empty) begin
            @(negedge rdclk);
            waited++;
        end
        // idle pipeline: FIFO write, issue, three stages
        assert (waited == pipeStages + 1)
            else failRun($sformatf("ERROR: latency expected 0x%h actual 0x%h",
                                   pipeStages + 1, waited));
        readOne(got);
    endtask

    task automatic edgeValues();
        wordT   edgeWords [4]  = '{32'h0000_0000, 32'hFFFF_FFFF, 32'h0000_0010, 32'hAAAA_AAAA};
        countT  edgeCounts [4] = '{6'd0, 6'd32, 6'd1, 6'd16};
        resultT got;
        for (int i = 0; i < 4; i++) begin
            sendWord(edgeWords[i]);
        end
        for (int i = 0; i < 4; i++) begin
            readOne(got);
            assert (got[wordBits +: countBits] === edgeCounts[i])
                else failRun($sformatf("ERROR: count expected 0x%h actual 0x%h",
                                       edgeCounts[i], got[wordBits +: countBits]));
        end
    endtask

    // producer and consumer side by side, optionally with coin-flip gaps
    task automatic runTraffic(input int count, input bit randomGaps);
        int sent;
        int got;
        sent = 0;
        got  = 0;
        while (got < count) begin
            if (sent < count && !almostFull &&
                (!randomGaps || $urandom_range(1, 0) == 1)) begin
                writeEnable = 1'b1;
                dataIn      = $urandom();
                expectedWords.push_back(dataIn);
                sent++;
            end else begin
                writeEnable = 1'b0;
            end
            if (!empty && (!randomGaps || $urandom_range(1, 0) == 1)) begin
                checkResult();
                readEnable = 1'b1;
                got++;
            end else begin
                readEnable = 1'b0;
            end
            @(negedge rdclk);
        end
        writeEnable = 1'b0;
        readEnable  = 1'b0;
    endtask

    task automatic burstStream();
        runTraffic(64, 1'b0);
    endtask

    task automatic fillAndDrain();
        int highCycles;
        int sent;
        int got;
        highCycles = 0;
        sent       = 0;
        got        = 0;
        while (highCycles < 20) begin
            if (!almostFull) begin
                writeEnable = 1'b1;
                dataIn      = $urandom();
                expectedWords.push_back(dataIn);
                sent++;
                highCycles = 0;
            end else begin
                writeEnable = 1'b0;
                highCycles++;
            end
            @(negedge rdclk);
        end
        writeEnable = 1'b0;
        while (got < sent) begin
            if (!empty) begin
                checkResult();
                readEnable = 1'b1;
                got++;
            end else begin
                readEnable = 1'b0;
            end
            @(negedge rdclk);
        end
        readEnable = 1'b0;
        checkNoExtraResults();
    endtask

    task automatic randomTraffic();
        runTraffic(200, 1'b1);
        checkNoExtraResults();
    endtask

    initial begin
        rdclk       = 1'b0;
        wrrst       = 1'b1;
        writeEnable = 1'b0;
        dataIn      = '0;
        readEnable  = 1'b0;
        seedDummy   = $urandom(67);

        checkReset();
        singleWord();
        edgeValues();
        burstStream();
        fillAndDrain();
        randomTraffic();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== src.f ====
common/streamPkg.sv
fifo/syncFifo.sv
source/popcountPipe.sv
source/countStreamTop.sv
tests/countStream_assertions.sv
tests/countStreamTb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the countStream testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -j 0 \
    --top-module countStreamTb \
    -f src.f \
    -o countStreamSim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

simOut=$(./obj_dir/countStreamSim 2>&1)
simStatus=$?
printf '%s\n' "$simOut"

if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if printf '%s\n' "$simOut" | grep -qx "Simulation PASSED"; then
    exit 0
fi

echo "pass message not found in the simulation output"
exit 1
